// File: sources.f
+incdir+include
rtl/afu_pkg.sv
rtl/afu_ctrl.sv
rtl/dcr_regfile.sv
rtl/accum_engine.sv
rtl/afu_top.sv
verification/afu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the afu testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module afu_tb \
    -Mdir obj_dir -o afu_sim \
    && ./obj_dir/afu_sim > sim.log 2>&1

grep -q ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/afu_tb.sv
// afu testbench driving the host bus through resets, registers, kernel runs and interrupts
`timescale 1ns/1ps
`default_nettype none

`include "afu_caps.svh"

module afu_tb;

    import afu_pkg::*;

    localparam int         WAIT_LIMIT     = 1000;
    localparam axil_data_t CTRL_IDLE_ONLY = 32'd1 << CTRL_IDLE_BIT;

    logic        clk;
    logic        reset;
    logic        awvalid;
    axil_addr_t  awaddr;
    logic        awready;
    logic        wvalid;
    axil_data_t  wdata;
    axil_strb_t  wstrb;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic        arvalid;
    axil_addr_t  araddr;
    logic        arready;
    logic        rvalid;
    axil_data_t  rdata;
    logic [1:0]  rresp;
    logic        rready;
    logic        interrupt;
    logic        result_valid;
    dcr_data_t   result_data;

    integer      seed;
    int          bp_max = 0;
    int          result_count = 0;
    dcr_data_t   last_result = '0;
    // host-side copy of the dcr value staging word
    dcr_data_t   staged_value = '0;

    afu_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready),
        .interrupt    (interrupt),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counts every done pulse and keeps its result
    always @(posedge clk) begin
        if (!reset && result_valid) begin
            result_count <= result_count + 1;
            last_result  <= result_data;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input axil_data_t got, input axil_data_t exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic wait_step(inout int n, input string what);
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) begin
            stop_with_failure($sformatf("timeout at %0t: %s", $time, what));
        end
    endtask

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic int backpressure_cycles();
        if (bp_max == 0) begin
            return 0;
        end
        return int'(next_random() % 32'(bp_max + 1));
    endfunction

    // bytes with their strobe set replace the old ones
    function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                               input axil_data_t new_word,
                                               input axil_strb_t strb);
        axil_data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb);
        int n;
        int hold;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        n = 0;
        while (!awready) wait_step(n, "write address was never accepted");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        n = 0;
        while (!wready) wait_step(n, "write data was never accepted");
        @(negedge clk);
        wvalid = 1'b0;
        n = 0;
        while (!bvalid) wait_step(n, "write response never came");
        hold = backpressure_cycles();
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        check_value("bresp", {30'b0, bresp}, 32'h0);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int n;
        int hold;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        n = 0;
        while (!arready) wait_step(n, "read address was never accepted");
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) wait_step(n, "read data never came");
        hold = backpressure_cycles();
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        check_value("rresp", {30'b0, rresp}, 32'h0);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic dcr_write(input dcr_addr_t idx, input dcr_data_t data, input axil_strb_t strb);
        axil_write(ADDR_DCR_0, {20'b0, idx}, 4'hF);
        axil_write(ADDR_DCR_1, data, strb);
        staged_value = merge_bytes(staged_value, data, strb);
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        while (result_count < target) wait_step(n, "result_valid never arrived");
    endtask

    // base goes last so that a partial strobe merges with the staged step value
    task automatic run_kernel(input dcr_data_t base, input dcr_data_t step,
                              input dcr_data_t count, input axil_strb_t base_strb);
        dcr_data_t  expected;
        axil_data_t rd;
        int         prev;
        dcr_write(DCR_COUNT, count, 4'hF);
        dcr_write(DCR_STEP, step, 4'hF);
        dcr_write(DCR_BASE, base, base_strb);
        expected = staged_value + step * count;
        prev = result_count;
        axil_write(ADDR_AP_CTRL, 32'd1 << CTRL_START_BIT, 4'hF);
        wait_results(prev + 1);
        check_value("result_data", last_result, expected);
        axil_read(ADDR_AP_CTRL, rd);
        check_value("ap_ctrl after run", rd, CTRL_IDLE_ONLY);
    endtask

    // responses must hold under back-pressure
    resp_held: assert property (
        @(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid
    ) else stop_with_failure($sformatf("mismatch at %0t: bvalid dropped before bready", $time));

    rdata_held: assert property (
        @(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata)
    ) else stop_with_failure($sformatf("mismatch at %0t: read response moved before rready",
                                       $time));

    result_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |=> !result_valid
    ) else stop_with_failure($sformatf("mismatch at %0t: result_valid longer than one cycle",
                                       $time));

    initial begin
        axil_data_t  rd;
        axil_data_t  val;
        axil_strb_t  strb;
        logic        gie_m;
        logic [1:0]  ier_m;
        logic [63:0] dev_word;
        logic [63:0] isa_word;
        dcr_data_t   base;
        dcr_data_t   step;
        dcr_data_t   count;
        dcr_data_t   first;
        int          n;
        int          prev;

        seed    = 32'h32a0f2e7;
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // handshake and event outputs come out of reset quiet
        check_value("awready after reset", {31'b0, awready}, 32'h1);
        check_value("arready after reset", {31'b0, arready}, 32'h1);
        check_value("wready after reset", {31'b0, wready}, 32'h0);
        check_value("bvalid after reset", {31'b0, bvalid}, 32'h0);
        check_value("rvalid after reset", {31'b0, rvalid}, 32'h0);
        check_value("interrupt after reset", {31'b0, interrupt}, 32'h0);
        check_value("result_valid after reset", {31'b0, result_valid}, 32'h0);

        // capability words rebuilt field by field from the documented layout
        dev_word        = '0;
        dev_word[15:0]  = `CAPS_IMPL_ID;
        dev_word[31:16] = `CAPS_VERSION;
        dev_word[39:32] = `CAPS_NUM_ENGINES;
        isa_word        = '0;
        isa_word[31:0]  = `CAPS_ISA_WORD;
        isa_word[63:48] = `CAPS_VERSION;

        // reset state and capability words
        axil_read(ADDR_AP_CTRL, rd);
        check_value("ap_ctrl after reset", rd, CTRL_IDLE_ONLY);
        axil_read(ADDR_GIE, rd);
        check_value("gie after reset", rd, 32'h0);
        axil_read(ADDR_IER, rd);
        check_value("ier after reset", rd, 32'h0);
        axil_read(ADDR_ISR, rd);
        check_value("isr after reset", rd, 32'h0);
        axil_read(ADDR_DEV_0, rd);
        check_value("dev_0", rd, dev_word[31:0]);
        axil_read(ADDR_DEV_1, rd);
        check_value("dev_1", rd, dev_word[63:32]);
        axil_read(ADDR_ISA_0, rd);
        check_value("isa_0", rd, isa_word[31:0]);
        axil_read(ADDR_ISA_1, rd);
        check_value("isa_1", rd, isa_word[63:32]);

        // strobed register writes with bit 0 of the strobe alternating
        gie_m = 1'b0;
        ier_m = 2'b00;
        for (int i = 0; i < 8; i++) begin
            val  = next_random();
            strb = axil_strb_t'(next_random());
            strb[0] = i[0];
            axil_write(ADDR_GIE, val, strb);
            if (strb[0]) gie_m = val[0];
            axil_read(ADDR_GIE, rd);
            check_value("gie read-back", rd, {31'b0, gie_m});
            val  = next_random();
            axil_write(ADDR_IER, val, strb);
            if (strb[0]) ier_m = val[1:0];
            axil_read(ADDR_IER, rd);
            check_value("ier read-back", rd, {30'b0, ier_m});
        end
        axil_write(ADDR_GIE, 32'h0, 4'hF);
        axil_write(ADDR_IER, 32'h0, 4'hF);

        // kernel runs with some partial strobes on the base word
        for (int i = 0; i < 5; i++) begin
            strb = (i[0]) ? (axil_strb_t'(next_random()) & 4'b0111) : 4'hF;
            run_kernel(next_random(), next_random(), next_random() % 8, strb);
        end

        // done interrupt set and cleared by toggle
        axil_write(ADDR_GIE, 32'h1, 4'hF);
        axil_write(ADDR_IER, 32'h1, 4'hF);
        run_kernel(next_random(), next_random(), next_random() % 8, 4'hF);
        n = 0;
        while (!interrupt) wait_step(n, "interrupt never rose after done");
        axil_read(ADDR_ISR, rd);
        check_value("isr after done", rd, 32'h1);
        axil_write(ADDR_ISR, 32'h1, 4'hF);
        axil_read(ADDR_ISR, rd);
        check_value("isr after toggle", rd, 32'h0);
        check_value("interrupt after toggle", {31'b0, interrupt}, 32'h0);
        axil_write(ADDR_GIE, 32'h0, 4'hF);
        axil_write(ADDR_IER, 32'h0, 4'hF);

        // auto-restart gives repeated equal results
        base  = next_random();
        step  = next_random();
        count = 3 + next_random() % 4;
        dcr_write(DCR_COUNT, count, 4'hF);
        dcr_write(DCR_STEP, step, 4'hF);
        dcr_write(DCR_BASE, base, 4'hF);
        prev = result_count;
        axil_write(ADDR_AP_CTRL, (32'd1 << CTRL_AUTO_BIT) | (32'd1 << CTRL_START_BIT), 4'hF);
        wait_results(prev + 1);
        first = last_result;
        axil_read(ADDR_AP_CTRL, rd);
        check_value("auto bit read-back", rd & (32'd1 << CTRL_AUTO_BIT), 32'd1 << CTRL_AUTO_BIT);
        wait_results(prev + 2);
        check_value("first auto result", first, base + step * count);
        check_value("second auto result", last_result, first);
        axil_write(ADDR_AP_CTRL, 32'h0, 4'hF);
        n = 0;
        axil_read(ADDR_AP_CTRL, rd);
        while (rd != CTRL_IDLE_ONLY) begin
            wait_step(n, "engine never went idle after auto-restart was cleared");
            axil_read(ADDR_AP_CTRL, rd);
        end

        // abort of a long run
        dcr_write(DCR_COUNT, 32'd200, 4'hF);
        prev = result_count;
        axil_write(ADDR_AP_CTRL, 32'd1 << CTRL_START_BIT, 4'hF);
        axil_read(ADDR_AP_CTRL, rd);
        check_value("ap_ctrl during long run", rd, 32'd1 << CTRL_START_BIT);
        axil_write(ADDR_AP_CTRL, 32'd1 << CTRL_RESET_BIT, 4'hF);
        for (int i = 0; i < 400; i++) begin
            @(negedge clk);
            if (result_count != prev) begin
                stop_with_failure("an aborted run still produced a result");
            end
        end
        axil_read(ADDR_AP_CTRL, rd);
        check_value("ap_ctrl after abort", rd, CTRL_IDLE_ONLY);

        // same traffic with stalled responses
        bp_max = 7;
        for (int i = 0; i < 4; i++) begin
            val = next_random();
            axil_write(ADDR_IER, val, 4'hF);
            axil_read(ADDR_IER, rd);
            check_value("ier under back-pressure", rd, {30'b0, val[1:0]});
            axil_read(ADDR_DEV_0, rd);
            check_value("dev_0 under back-pressure", rd, dev_word[31:0]);
        end
        axil_write(ADDR_IER, 32'h0, 4'hF);
        for (int i = 0; i < 3; i++) begin
            strb = (i == 1) ? 4'b1100 : 4'hF;
            run_kernel(next_random(), next_random(), next_random() % 8, strb);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/afu_top.sv
// afu top level: host control, dcr register file and accumulate engine
`timescale 1ns/1ps
`default_nettype none

module afu_top (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  awvalid,
    input  afu_pkg::axil_addr_t  awaddr,
    output logic                 awready,

    input  wire                  wvalid,
    input  afu_pkg::axil_data_t  wdata,
    input  afu_pkg::axil_strb_t  wstrb,
    output logic                 wready,

    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  wire                  bready,

    input  wire                  arvalid,
    input  afu_pkg::axil_addr_t  araddr,
    output logic                 arready,

    output logic                 rvalid,
    output afu_pkg::axil_data_t  rdata,
    output logic [1:0]           rresp,
    input  wire                  rready,

    output logic                 interrupt,
    output logic                 result_valid,
    output afu_pkg::dcr_data_t   result_data
);

    import afu_pkg::*;

    logic      ap_start;
    logic      ap_reset;
    logic      ap_done;
    logic      ap_ready;
    logic      ap_idle;
    logic      dcr_wr_valid;
    dcr_addr_t dcr_wr_addr;
    dcr_data_t dcr_wr_data;
    dcr_data_t cfg_base;
    dcr_data_t cfg_step;
    dcr_data_t cfg_count;

    afu_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready),
        .ap_start     (ap_start),
        .ap_reset     (ap_reset),
        .ap_done      (ap_done),
        .ap_ready     (ap_ready),
        .ap_idle      (ap_idle),
        .interrupt    (interrupt),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data)
    );

    dcr_regfile u_dcr (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .cfg_base     (cfg_base),
        .cfg_step     (cfg_step),
        .cfg_count    (cfg_count)
    );

    accum_engine u_engine (
        .clk          (clk),
        .reset        (reset),
        .ap_start     (ap_start),
        .ap_reset     (ap_reset),
        .ap_done      (ap_done),
        .ap_ready     (ap_ready),
        .ap_idle      (ap_idle),
        .cfg_base     (cfg_base),
        .cfg_step     (cfg_step),
        .cfg_count    (cfg_count),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// File: rtl/accum_engine.sv
// stand-in compute engine: accumulates base plus step, count times, with ap handshake
`timescale 1ns/1ps
`default_nettype none

module accum_engine (
    input  wire                 clk,
    input  wire                 reset,

    input  wire                 ap_start,
    input  wire                 ap_reset,
    output logic                ap_done,
    output logic                ap_ready,
    output logic                ap_idle,

    input  afu_pkg::dcr_data_t  cfg_base,
    input  afu_pkg::dcr_data_t  cfg_step,
    input  afu_pkg::dcr_data_t  cfg_count,

    output logic                result_valid,
    output afu_pkg::dcr_data_t  result_data
);

    import afu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FINISH
    } state_t;

    state_t    state;
    dcr_data_t remaining;
    dcr_data_t step_q;
    dcr_data_t acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else if (ap_reset) begin
            // abort drops the run without a done
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ap_start) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    // a zero count still spends one cycle here
                    if (remaining <= 1) begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // datapath, configuration captured at acceptance
    always_ff @(posedge clk) begin
        if (state == S_IDLE && ap_start) begin
            acc       <= cfg_base;
            step_q    <= cfg_step;
            remaining <= cfg_count;
        end else if (state == S_RUN && remaining != 0) begin
            acc       <= acc + step_q;
            remaining <= remaining - 1'b1;
        end
    end

    assign ap_idle      = (state == S_IDLE);
    assign ap_done      = (state == S_FINISH);
    assign ap_ready     = (state == S_FINISH);
    assign result_valid = (state == S_FINISH);
    assign result_data  = acc;

    // a done always follows at least one busy cycle
    a_done_not_from_idle: assert property (
        @(posedge clk) disable iff (reset)
        ap_done |-> !$past(ap_idle)
    );

endmodule

`default_nettype wire

// File: rtl/dcr_regfile.sv
// dcr register file: decodes dcr writes into the engine configuration registers
`timescale 1ns/1ps
`default_nettype none

module dcr_regfile (
    input  wire                 clk,
    input  wire                 reset,

    input  wire                 dcr_wr_valid,
    input  afu_pkg::dcr_addr_t  dcr_wr_addr,
    input  afu_pkg::dcr_data_t  dcr_wr_data,

    output afu_pkg::dcr_data_t  cfg_base,
    output afu_pkg::dcr_data_t  cfg_step,
    output afu_pkg::dcr_data_t  cfg_count
);

    import afu_pkg::*;

    logic wr_mapped;

    assign wr_mapped = (dcr_wr_addr == DCR_BASE)
                    || (dcr_wr_addr == DCR_STEP)
                    || (dcr_wr_addr == DCR_COUNT);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_base  <= '0;
            cfg_step  <= '0;
            cfg_count <= DCR_COUNT_RESET;
        end else if (dcr_wr_valid) begin
            case (dcr_wr_addr)
                DCR_BASE:  cfg_base  <= dcr_wr_data;
                DCR_STEP:  cfg_step  <= dcr_wr_data;
                DCR_COUNT: cfg_count <= dcr_wr_data;
                // other indices belong to nothing here
                default: begin
                end
            endcase
        end
    end

    // partial strobes on an unset staging word would leak x into the engine
    a_dcr_known: assert property (
        @(posedge clk) disable iff (reset)
        dcr_wr_valid && wr_mapped |-> !$isunknown(dcr_wr_data)
    );

endmodule

`default_nettype wire

// File: rtl/afu_ctrl.sv
// afu host control: axi4-lite slave with start/interrupt registers and dcr window
`timescale 1ns/1ps
`default_nettype none

`include "afu_caps.svh"

module afu_ctrl (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  awvalid,
    input  afu_pkg::axil_addr_t  awaddr,
    output logic                 awready,

    input  wire                  wvalid,
    input  afu_pkg::axil_data_t  wdata,
    input  afu_pkg::axil_strb_t  wstrb,
    output logic                 wready,

    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  wire                  bready,

    input  wire                  arvalid,
    input  afu_pkg::axil_addr_t  araddr,
    output logic                 arready,

    output logic                 rvalid,
    output afu_pkg::axil_data_t  rdata,
    output logic [1:0]           rresp,
    input  wire                  rready,

    output logic                 ap_start,
    output logic                 ap_reset,
    input  wire                  ap_done,
    input  wire                  ap_ready,
    input  wire                  ap_idle,
    output logic                 interrupt,

    output logic                 dcr_wr_valid,
    output afu_pkg::dcr_addr_t   dcr_wr_addr,
    output afu_pkg::dcr_data_t   dcr_wr_data
);

    import afu_pkg::*;

    typedef enum logic [1:0] {
        W_ADDR,
        W_DATA,
        W_RESP
    } wstate_t;

    typedef enum logic [1:0] {
        R_ADDR,
        R_DATA,
        R_RESP
    } rstate_t;

    wstate_t    wstate;
    rstate_t    rstate;
    axil_addr_t waddr;
    axil_addr_t raddr;
    axil_data_t wmask;
    axil_data_t rdata_mux;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    logic       auto_restart;
    logic       gie;
    logic [1:0] ier;
    logic [1:0] isr;
    logic [1:0] isr_next;

    // dcr staging, index and value
    dcr_addr_t dcr_idx;
    dcr_data_t dcr_val;

    logic [63:0] dev_caps;
    logic [63:0] isa_caps;

    assign dev_caps = {24'h0, `CAPS_NUM_ENGINES, `CAPS_VERSION, `CAPS_IMPL_ID};
    assign isa_caps = {`CAPS_VERSION, 16'h0, `CAPS_ISA_WORD};

    // write channel
    assign awready = (wstate == W_ADDR);
    assign wready  = (wstate == W_DATA);
    assign bvalid  = (wstate == W_RESP);
    assign bresp   = AXIL_RESP_OKAY;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    always_comb begin
        for (int i = 0; i < AXIL_STRB_W; i++) begin
            wmask[8*i +: 8] = {8{wstrb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wstate <= W_ADDR;
        end else begin
            case (wstate)
                W_ADDR:  wstate <= aw_fire ? W_DATA : W_ADDR;
                W_DATA:  wstate <= w_fire ? W_RESP : W_DATA;
                W_RESP:  wstate <= b_fire ? W_ADDR : W_RESP;
                default: wstate <= W_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            waddr <= awaddr;
        end
    end

    // status bits toggle on a write of 1 and set on engine events at any time
    always_comb begin
        isr_next = isr;
        if (w_fire && waddr == ADDR_ISR && wstrb[0]) begin
            isr_next = isr ^ wdata[1:0];
        end
        if (ier[0] && ap_done) begin
            isr_next[0] = 1'b1;
        end
        if (ier[1] && ap_ready) begin
            isr_next[1] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ap_start     <= 1'b0;
            ap_reset     <= 1'b0;
            auto_restart <= 1'b0;
            gie          <= 1'b0;
            ier          <= '0;
            isr          <= '0;
            dcr_idx      <= '0;
            dcr_val      <= '0;
            dcr_wr_valid <= 1'b0;
        end else begin
            ap_reset     <= 1'b0;
            dcr_wr_valid <= 1'b0;
            isr          <= isr_next;

            // start is consumed by the engine handshake
            if (ap_ready) begin
                ap_start <= auto_restart;
            end

            if (w_fire) begin
                case (waddr)
                    ADDR_AP_CTRL: begin
                        if (wstrb[0]) begin
                            auto_restart <= wdata[CTRL_AUTO_BIT];
                            if (wdata[CTRL_RESET_BIT]) begin
                                // abort also drops a pending start
                                ap_reset <= 1'b1;
                                ap_start <= 1'b0;
                            end else if (wdata[CTRL_START_BIT]) begin
                                ap_start <= 1'b1;
                            end
                        end
                    end
                    ADDR_GIE: begin
                        if (wstrb[0]) begin
                            gie <= wdata[0];
                        end
                    end
                    ADDR_IER: begin
                        if (wstrb[0]) begin
                            ier <= wdata[1:0];
                        end
                    end
                    ADDR_DCR_0: begin
                        dcr_idx <= (wdata[DCR_ADDR_W-1:0] & wmask[DCR_ADDR_W-1:0])
                                 | (dcr_idx & ~wmask[DCR_ADDR_W-1:0]);
                    end
                    ADDR_DCR_1: begin
                        dcr_val      <= (wdata & wmask) | (dcr_val & ~wmask);
                        dcr_wr_valid <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign interrupt   = gie && (|isr);
    assign dcr_wr_addr = dcr_idx;
    assign dcr_wr_data = dcr_val;

    // read channel
    assign arready = (rstate == R_ADDR);
    assign rvalid  = (rstate == R_RESP);
    assign rresp   = AXIL_RESP_OKAY;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rstate <= R_ADDR;
        end else begin
            case (rstate)
                R_ADDR:  rstate <= ar_fire ? R_DATA : R_ADDR;
                R_DATA:  rstate <= R_RESP;
                R_RESP:  rstate <= r_fire ? R_ADDR : R_RESP;
                default: rstate <= R_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            raddr <= araddr;
        end
    end

    always_comb begin
        rdata_mux = '0;
        case (raddr)
            ADDR_AP_CTRL: begin
                rdata_mux[CTRL_START_BIT] = ap_start;
                rdata_mux[CTRL_DONE_BIT]  = ap_done;
                rdata_mux[CTRL_IDLE_BIT]  = ap_idle;
                rdata_mux[CTRL_READY_BIT] = ap_ready;
                rdata_mux[CTRL_AUTO_BIT]  = auto_restart;
            end
            ADDR_GIE:   rdata_mux[0]   = gie;
            ADDR_IER:   rdata_mux[1:0] = ier;
            ADDR_ISR:   rdata_mux[1:0] = isr;
            ADDR_DEV_0: rdata_mux = dev_caps[31:0];
            ADDR_DEV_1: rdata_mux = dev_caps[63:32];
            ADDR_ISA_0: rdata_mux = isa_caps[31:0];
            ADDR_ISA_1: rdata_mux = isa_caps[63:32];
            default: begin
            end
        endcase
    end

    // sampled once, then frozen for the whole response
    always_ff @(posedge clk) begin
        if (rstate == R_DATA) begin
            rdata <= rdata_mux;
        end
    end

    // a stalled write response stays up until the host takes it
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid
    );

    // read data may not move under a stalled response
    a_rdata_stable: assert property (
        @(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

`default_nettype wire

// File: rtl/afu_pkg.sv
// afu shared package: host register offsets, dcr indices, widths and vector types
`default_nettype none

package afu_pkg;

    // bus and dcr widths
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
    localparam int DCR_ADDR_W  = 12;
    localparam int DCR_DATA_W  = 32;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [DCR_ADDR_W-1:0]  dcr_addr_t;
    typedef logic [DCR_DATA_W-1:0]  dcr_data_t;

    // host register map
    localparam axil_addr_t ADDR_AP_CTRL = 8'h00;
    localparam axil_addr_t ADDR_GIE     = 8'h04;
    localparam axil_addr_t ADDR_IER     = 8'h08;
    localparam axil_addr_t ADDR_ISR     = 8'h0C;
    // capability words, low half first
    localparam axil_addr_t ADDR_DEV_0   = 8'h10;
    localparam axil_addr_t ADDR_DEV_1   = 8'h14;
    localparam axil_addr_t ADDR_ISA_0   = 8'h18;
    localparam axil_addr_t ADDR_ISA_1   = 8'h1C;
    // dcr window: index first, then value which fires the write
    localparam axil_addr_t ADDR_DCR_0   = 8'h20;
    localparam axil_addr_t ADDR_DCR_1   = 8'h24;

    // configuration register indices
    localparam dcr_addr_t DCR_BASE  = 12'd1;
    localparam dcr_addr_t DCR_STEP  = 12'd2;
    localparam dcr_addr_t DCR_COUNT = 12'd3;

    localparam dcr_data_t DCR_COUNT_RESET = 32'd1;

    // bit positions in the control register
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DONE_BIT  = 1;
    localparam int CTRL_IDLE_BIT  = 2;
    localparam int CTRL_READY_BIT = 3;
    localparam int CTRL_RESET_BIT = 4;
    localparam int CTRL_AUTO_BIT  = 7;

    // the only response this block ever returns
    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: include/afu_caps.svh
// afu capability constants, assembled into the dev and isa words of the host map
`ifndef AFU_CAPS_SVH
`define AFU_CAPS_SVH

// identifies this accelerator family
`define CAPS_IMPL_ID      16'h4143

// major in the upper byte, minor in the lower byte
`define CAPS_VERSION      16'h0103

`define CAPS_NUM_ENGINES  8'd1

// supported operation set, bit 0 is accumulate
`define CAPS_ISA_WORD     32'h0000_1101

// dev word layout (64 bits):
//   [63:40] zero, [39:32] num engines, [31:16] version, [15:0] impl id
// isa word layout (64 bits):
//   [63:48] version, [47:32] zero, [31:0] isa word

`endif
